//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= tinker_core.f
TOP       ?= tinker_core_tb
RTL_TOP   ?= tinker_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tinker_core_tb.sv
`timescale 1ns/1ns

module tinker_core_tb
    import tinker_pkg::*;
();

    localparam int HS_TIMEOUT   = 40;     // cycles per handshake phase
    localparam int HALT_TIMEOUT = 2000;

    logic  clk = 1'b0;
    logic  reset;
    logic  run;
    logic  hlt;
    logic  host_req;
    logic  host_write;
    addr_t host_addr;
    word_t host_wdata;
    logic  host_ack;
    word_t host_rdata;

    integer     seed = 32'h9b81;
    int         errors;
    int         checks;
    logic       timed_out = 1'b0;      // a wait ran out of cycles
    logic [7:0] ref_mem [MEM_BYTES];   // model's byte memory
    instr_t     prog [$];              // program, from PC_RESET_ADDR
    addr_t      pre_addr [$];          // data preload list
    word_t      pre_data [$];
    addr_t      check_addrs [$];       // read back after each run

    tinker_core tinker_core_inst (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .hlt        (hlt),
        .host_req   (host_req),
        .host_write (host_write),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata)
    );

    always #10 clk = ~clk;   // 20 ns

    function automatic instr_t encode(input opcode_t op, input int rd, input int rs,
                                      input int rt, input int lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), 12'(lit)};
    endfunction

    function automatic word_t ref_read(input addr_t a);
        word_t d;
        addr_t b;
        for (int k = 0; k < 8; k++) begin
            b = a + addr_t'(k);
            d[8*k +: 8] = ref_mem[b[MEM_AW-1:0]];   // little-endian
        end
        return d;
    endfunction

    function automatic void ref_write(input addr_t a, input word_t d);
        addr_t b;
        for (int k = 0; k < 8; k++) begin
            b = a + addr_t'(k);
            ref_mem[b[MEM_AW-1:0]] = d[8*k +: 8];
        end
    endfunction

    // sequential ISA model, one instruction at a time, stops at halt
    function automatic void run_model();
        word_t    r [32];
        opcode_t  op;
        reg_idx_t rd, rs, rt;
        lit_t     lit;
        word_t    lz, ls;
        r = '{default: '0};   // regs clear after reset
        foreach (prog[pc]) begin
            {op, rd, rs, rt, lit} = prog[pc];
            lz = {52'd0, lit};
            ls = {{52{lit[11]}}, lit};   // offsets are signed
            case (op)
                OP_ADD:    r[rd] = r[rs] + r[rt];
                OP_ADDI:   r[rd] = r[rd] + lz;
                OP_SUB:    r[rd] = r[rs] - r[rt];
                OP_SUBI:   r[rd] = r[rd] - lz;
                OP_MUL:    r[rd] = r[rs] * r[rt];
                OP_AND:    r[rd] = r[rs] & r[rt];
                OP_OR:     r[rd] = r[rs] | r[rt];
                OP_XOR:    r[rd] = r[rs] ^ r[rt];
                OP_NOT:    r[rd] = ~r[rs];
                OP_SHFTR:  r[rd] = r[rs] >> r[rt];
                OP_SHFTRI: r[rd] = r[rd] >> lz;
                OP_SHFTL:  r[rd] = r[rs] << r[rt];
                OP_SHFTLI: r[rd] = r[rd] << lz;
                OP_MOV_RR: r[rd] = r[rs];
                OP_MOV_RL: r[rd] = {r[rd][63:12], lit};   // low 12 bits only
                OP_LOAD:   r[rd] = ref_read(addr_t'(r[rs] + ls));
                OP_STORE:  ref_write(addr_t'(r[rd] + ls), r[rs]);
                OP_HALT:   return;
                default:   ;
            endcase
        end
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    // hung wait, this process stops here for good
    task automatic stop_on_timeout(input string what);
        errors++;
        $display("%s", what);
        timed_out = 1'b1;
        wait (!timed_out);
    endtask

    // ends the run once any wait has timed out
    initial begin
        @(posedge timed_out);
        finish_run();
    end

    // one four-phase transfer, sampled on the falling edge
    task automatic host_access(input logic wr, input addr_t a, input word_t d,
                               output word_t q);
        int n;
        @(posedge clk);
        host_write <= wr;
        host_addr  <= a;
        host_wdata <= d;
        host_req   <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!host_ack && n < HS_TIMEOUT);
        if (!host_ack) begin
            stop_on_timeout($sformatf("host_ack never rose for a request at address %h", a));
        end else begin
            q = host_rdata;   // valid with ack
            @(posedge clk);
            host_req <= 1'b0;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (host_ack && n < HS_TIMEOUT);
            if (host_ack)
                stop_on_timeout("host_ack stayed high after host_req was dropped");
        end
    endtask

    task automatic host_store(input addr_t a, input word_t d);
        word_t q;
        host_access(1'b1, a, d, q);
        ref_write(a, d);   // model memory tracks every host write
    endtask

    function automatic void new_program();
        prog.delete();
        pre_addr.delete();
        pre_data.delete();
        check_addrs.delete();
    endfunction

    function automatic void preload(input addr_t a, input word_t d);
        pre_addr.push_back(a);
        pre_data.push_back(d);
    endfunction

    // park, reset, load, run to hlt, then read back
    task automatic run_program(input int hold);
        word_t q;
        int    n;
        @(posedge clk);
        run   <= 1'b0;
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        if (prog.size() % 2 != 0)
            prog.push_back(NOP_INSTR);   // pad to a whole doubleword
        for (int i = 0; i < prog.size(); i += 2)
            host_store(PC_RESET_ADDR + addr_t'(4 * i), {prog[i+1], prog[i]});
        foreach (pre_addr[i])
            host_store(pre_addr[i], pre_data[i]);
        run_model();
        @(posedge clk);
        run <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!hlt && n < HALT_TIMEOUT);
        if (!hlt) begin
            stop_on_timeout($sformatf("hlt did not rise within %0d cycles", HALT_TIMEOUT));
        end else begin
            for (int i = 0; i < hold; i++) begin
                @(negedge clk);
                check_value("hlt", word_t'(hlt), 64'd1);   // sticky while run high
            end
            @(posedge clk);
            run <= 1'b0;
            foreach (check_addrs[i]) begin
                host_access(1'b0, check_addrs[i], '0, q);
                check_value($sformatf("host_rdata @%h", check_addrs[i]), q,
                            ref_read(check_addrs[i]));
            end
        end
    endtask

    // back-to-back dependent chain over every ALU opcode
    function automatic void alu_chain_program();
        new_program();
        prog.push_back(encode(OP_MOV_RL, 1, 0, 0, 'h7a5));
        prog.push_back(encode(OP_ADDI, 1, 0, 0, 'h321));      // rd from EX/MEM
        prog.push_back(encode(OP_SHFTLI, 1, 0, 0, 20));
        prog.push_back(encode(OP_MOV_RR, 2, 1, 0, 0));
        prog.push_back(encode(OP_SUBI, 2, 0, 0, 'h055));
        prog.push_back(encode(OP_ADD, 3, 1, 2, 0));
        prog.push_back(encode(OP_SUB, 4, 3, 1, 0));
        prog.push_back(encode(OP_MUL, 5, 4, 3, 0));           // rt via MEM/WB
        prog.push_back(encode(OP_AND, 6, 5, 3, 0));
        prog.push_back(encode(OP_OR, 7, 6, 1, 0));
        prog.push_back(encode(OP_XOR, 8, 7, 5, 0));
        prog.push_back(encode(OP_NOT, 9, 8, 0, 0));
        prog.push_back(encode(OP_MOV_RL, 10, 0, 0, 'h00c));
        prog.push_back(encode(OP_SHFTL, 11, 9, 10, 0));
        prog.push_back(encode(OP_SHFTR, 12, 11, 10, 0));
        prog.push_back(encode(OP_SHFTRI, 12, 0, 0, 3));
        prog.push_back(encode(OP_ADD, 13, 12, 9, 0));
        prog.push_back(encode(OP_MOV_RL, 14, 0, 0, 'h900));   // store base
        for (int k = 1; k <= 13; k++) begin
            prog.push_back(encode(OP_STORE, 14, k, 0, 8 * k - 16));   // first one at -8
            check_addrs.push_back(addr_t'(32'h900 + 8 * k - 16));
        end
        prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
    endfunction

    // each load is used by the very next instruction
    function automatic void load_use_program();
        new_program();
        preload(32'h800, {$random(seed), $random(seed)});
        preload(32'h808, {$random(seed), $random(seed)});
        preload(32'h830, 64'h840);   // pointer for the store address case
        prog.push_back(encode(OP_MOV_RL, 20, 0, 0, 'h800));
        prog.push_back(encode(OP_LOAD, 1, 20, 0, 0));
        prog.push_back(encode(OP_ADDI, 1, 0, 0, 5));          // use in rd
        prog.push_back(encode(OP_LOAD, 2, 20, 0, 8));
        prog.push_back(encode(OP_ADD, 3, 2, 1, 0));           // use in rs
        prog.push_back(encode(OP_LOAD, 4, 20, 0, 0));
        prog.push_back(encode(OP_SUB, 5, 3, 4, 0));           // use in rt
        prog.push_back(encode(OP_LOAD, 6, 20, 0, 8));
        prog.push_back(encode(OP_STORE, 20, 6, 0, 'h10));     // store data
        prog.push_back(encode(OP_STORE, 20, 1, 0, 'h18));
        prog.push_back(encode(OP_STORE, 20, 3, 0, 'h20));
        prog.push_back(encode(OP_STORE, 20, 5, 0, 'h28));
        prog.push_back(encode(OP_LOAD, 7, 20, 0, 'h30));
        prog.push_back(encode(OP_STORE, 7, 3, 0, 0));         // address from the load
        prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
        for (int k = 2; k <= 5; k++)
            check_addrs.push_back(addr_t'(32'h800 + 8 * k));
        check_addrs.push_back(32'h840);
    endfunction

    function automatic void halt_program();
        new_program();
        preload(32'ha00, {$random(seed), $random(seed)});
        preload(32'ha08, {$random(seed), $random(seed)});   // must survive
        prog.push_back(encode(OP_MOV_RL, 1, 0, 0, 'h5a5));
        prog.push_back(encode(OP_MOV_RL, 2, 0, 0, 'ha00));
        prog.push_back(encode(OP_STORE, 2, 1, 0, 0));
        prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
        prog.push_back(encode(OP_STORE, 2, 1, 0, 8));         // never executes
        check_addrs.push_back(32'ha00);
        check_addrs.push_back(32'ha08);
    endfunction

    // r1..r7 random work, r8 fixed base at 0xc00
    function automatic void random_program();
        opcode_t    ops [17] = '{OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL, OP_AND,
                                 OP_OR, OP_XOR, OP_NOT, OP_SHFTR, OP_SHFTRI, OP_SHFTL,
                                 OP_SHFTLI, OP_MOV_RR, OP_MOV_RL, OP_LOAD, OP_STORE};
        opcode_t    op;
        logic [4:0] pick;
        int         rd, rs, rt, lit;
        new_program();
        prog.push_back(encode(OP_MOV_RL, 8, 0, 0, 'hc00));
        for (int k = 0; k < 16; k++)
            preload(addr_t'(32'hc00 + 8 * k), {$random(seed), $random(seed)});
        for (int k = 1; k <= 7; k++)
            prog.push_back(encode(OP_LOAD, k, 8, 0, 8 * k));   // seed the registers
        for (int i = 0; i < 24; i++) begin
            pick = 5'($unsigned($random(seed)) % 17);
            op   = ops[pick];
            rd   = 1 + $unsigned($random(seed)) % 7;
            rs   = 1 + $unsigned($random(seed)) % 7;
            rt   = 1 + $unsigned($random(seed)) % 7;
            lit  = $unsigned($random(seed)) % 4096;
            if (op == OP_SHFTRI || op == OP_SHFTLI)
                lit = lit % 64;
            if (op == OP_LOAD)
                rs = 8;
            if (op == OP_STORE)
                rd = 8;
            if (op == OP_LOAD || op == OP_STORE)
                lit = 8 * (lit % 16);   // stay inside the data block
            prog.push_back(encode(op, rd, rs, rt, lit));
        end
        for (int k = 1; k <= 7; k++)
            prog.push_back(encode(OP_STORE, 8, k, 0, 'h80 + 8 * (k - 1)));
        prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
        for (int k = 0; k < 23; k++)
            check_addrs.push_back(addr_t'(32'hc00 + 8 * k));
    endfunction

    initial begin
        word_t d;
        word_t q;
        reset      = 1'b1;
        run        = 1'b0;
        host_req   = 1'b0;
        host_write = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        errors     = 0;
        checks     = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("hlt", word_t'(hlt), '0);
        check_value("host_ack", word_t'(host_ack), '0);
        // plain host write then read back
        d = {$random(seed), $random(seed)};
        host_store(32'h100, d);
        host_access(1'b0, 32'h100, '0, q);
        check_value("host_rdata", q, d);
        alu_chain_program();
        run_program(0);
        load_use_program();
        run_program(0);
        halt_program();
        run_program(20);
        repeat (20) begin
            random_program();
            run_program(0);
        end
        finish_run();
    end

endmodule

//--- tinker_core.f
verilog/tinker_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/unified_memory.sv
verilog/tinker_core.sv
tb/tinker_core_tb.sv

//--- verilog/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
    import tinker_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     run,
    input  ifid_t    ifid,
    output reg_idx_t rd_idx,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    input  word_t    rd_data,
    input  word_t    rs_data,
    input  word_t    rt_data,
    output logic     stall,
    output logic     halting,
    output idex_t    idex
);

    opcode_t opcode;
    lit_t    lit;
    ctrl_t   ctrl;
    logic    halt_seen;   // halt already went down the pipe

    // field split
    assign opcode = ifid.instr[31:27];
    assign rd_idx = ifid.instr[26:22];
    assign rs_idx = ifid.instr[21:17];
    assign rt_idx = ifid.instr[16:12];
    assign lit    = ifid.instr[11:0];

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL,
            OP_AND, OP_OR, OP_XOR, OP_NOT,
            OP_SHFTR, OP_SHFTRI, OP_SHFTL, OP_SHFTLI,
            OP_MOV_RR, OP_MOV_RL: ctrl.reg_write = 1'b1;
            OP_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_STORE: ctrl.mem_write = 1'b1;
            OP_HALT:  ctrl.halt      = 1'b1;
            default:  ctrl = '0;   // dropped opcodes run as bubbles
        endcase
    end

    // load in EX, its dest read here -> wait one cycle
    // rd checked too, immediate forms and store read it
    assign stall = idex.ctrl.mem_read &&
                   ((idex.rd == rd_idx) || (idex.rd == rs_idx) || (idex.rd == rt_idx));

    assign halting = (ctrl.halt && !stall) || halt_seen;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            halt_seen <= 1'b0;
        end else if (!run) begin
            halt_seen <= 1'b0;
        end else if (ctrl.halt && !stall) begin
            halt_seen <= 1'b1;
        end
    end

    // ID/EX register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex <= '0;
        end else if (!run || stall) begin
            idex <= '0;   // bubble
        end else begin
            idex.ctrl   <= ctrl;
            idex.opcode <= opcode;
            idex.rd     <= rd_idx;
            idex.rs     <= rs_idx;
            idex.rt     <= rt_idx;
            idex.lit    <= lit;
            idex.rd_val <= rd_data;
            idex.rs_val <= rs_data;
            idex.rt_val <= rt_data;
        end
    end

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ns

module execute_stage
    import tinker_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   run,
    input  idex_t  idex,
    input  wb_t    wb,
    output exmem_t exmem
);

    word_t rd_fwd, rs_fwd, rt_fwd;   // operands after forwarding
    word_t lit_zext, lit_sext;
    word_t alu_out;

    // newest producer wins: EX/MEM, then MEM/WB, then ID/EX copy
    function automatic word_t fwd(input reg_idx_t idx, input word_t id_val);
        if (exmem.ctrl.reg_write && (exmem.dest == idx))
            return exmem.alu_result;
        else if (wb.we && (wb.dest == idx))
            return wb.data;
        return id_val;
    endfunction

    always_comb begin
        rd_fwd = fwd(idex.rd, idex.rd_val);
        rs_fwd = fwd(idex.rs, idex.rs_val);
        rt_fwd = fwd(idex.rt, idex.rt_val);
    end

    assign lit_zext = {52'd0, idex.lit};
    assign lit_sext = {{52{idex.lit[11]}}, idex.lit};   // address offsets only

    always_comb begin
        case (idex.opcode)
            OP_ADD:    alu_out = rs_fwd + rt_fwd;
            OP_ADDI:   alu_out = rd_fwd + lit_zext;
            OP_SUB:    alu_out = rs_fwd - rt_fwd;
            OP_SUBI:   alu_out = rd_fwd - lit_zext;
            OP_MUL:    alu_out = rs_fwd * rt_fwd;     // low 64 bits
            OP_AND:    alu_out = rs_fwd & rt_fwd;
            OP_OR:     alu_out = rs_fwd | rt_fwd;
            OP_XOR:    alu_out = rs_fwd ^ rt_fwd;
            OP_NOT:    alu_out = ~rs_fwd;
            OP_SHFTR:  alu_out = rs_fwd >> rt_fwd;
            OP_SHFTRI: alu_out = rd_fwd >> lit_zext;
            OP_SHFTL:  alu_out = rs_fwd << rt_fwd;
            OP_SHFTLI: alu_out = rd_fwd << lit_zext;
            OP_MOV_RR: alu_out = rs_fwd;
            OP_MOV_RL: alu_out = {rd_fwd[63:12], idex.lit};   // only low 12 bits replaced
            OP_LOAD:   alu_out = rs_fwd + lit_sext;
            OP_STORE:  alu_out = rd_fwd + lit_sext;
            default:   alu_out = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem <= '0;
        end else if (!run) begin
            exmem <= '0;
        end else begin
            exmem.ctrl       <= idex.ctrl;
            exmem.alu_result <= alu_out;
            exmem.store_data <= rs_fwd;   // store writes rs
            exmem.dest       <= idex.rd;
        end
    end

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
    import tinker_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   run,
    input  logic   stall,
    input  logic   halting,
    output addr_t  fetch_addr,
    input  instr_t fetch_instr,   // combinational read at pc
    output ifid_t  ifid
);

    addr_t pc;

    assign fetch_addr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= PC_RESET_ADDR;
            ifid.instr <= NOP_INSTR;
        end else if (!run) begin
            pc         <= PC_RESET_ADDR;   // parked at reset state
            ifid.instr <= NOP_INSTR;
        end else if (halting) begin
            ifid.instr <= NOP_INSTR;       // drain, pc frozen
        end else if (!stall) begin
            pc         <= pc + 32'd4;
            ifid.instr <= fetch_instr;
        end
        // stall: pc and IF/ID hold
    end

endmodule

//--- verilog/memory_stage.sv
`timescale 1ns/1ns

module memory_stage
    import tinker_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   run,
    input  exmem_t exmem,
    output addr_t  data_addr,
    output logic   data_we,
    output word_t  data_wdata,
    input  word_t  data_rdata,   // same-cycle load data
    output wb_t    wb,
    output logic   hlt
);

    memwb_t memwb;

    assign data_addr  = exmem.alu_result[31:0];
    assign data_we    = exmem.ctrl.mem_write;
    assign data_wdata = exmem.store_data;

    // writeback mux
    assign wb.we   = memwb.ctrl.reg_write;
    assign wb.dest = memwb.dest;
    assign wb.data = memwb.ctrl.mem_to_reg ? memwb.mem_data : memwb.alu_result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memwb <= '0;
            hlt   <= 1'b0;
        end else if (!run) begin
            memwb <= '0;
            hlt   <= 1'b0;   // cleared only by run low
        end else begin
            memwb.ctrl       <= exmem.ctrl;
            memwb.mem_data   <= data_rdata;
            memwb.alu_result <= exmem.alu_result;
            memwb.dest       <= exmem.dest;
            hlt              <= hlt | exmem.ctrl.halt;   // rises with halt in MEM/WB
        end
    end

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ns

module register_file
    import tinker_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  wb_t      wb,
    input  reg_idx_t rd_idx,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rd_data,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [32];

    // write-through so decode sees a same-cycle writeback
    function automatic word_t read_port(input reg_idx_t idx);
        if (wb.we && (wb.dest == idx))
            return wb.data;
        return regs[idx];
    endfunction

    always_comb begin
        rd_data = read_port(rd_idx);
        rs_data = read_port(rs_idx);
        rt_data = read_port(rt_idx);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb.we) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

//--- verilog/tinker_core.sv
`timescale 1ns/1ns

module tinker_core
    import tinker_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  run,          // low: pipeline held, host owns memory
    output logic  hlt,
    input  logic  host_req,
    input  logic  host_write,
    input  addr_t host_addr,
    input  word_t host_wdata,
    output logic  host_ack,
    output word_t host_rdata
);

    ifid_t    ifid;
    idex_t    idex;
    exmem_t   exmem;
    wb_t      wb;
    logic     stall;       // load-use, from decode
    logic     halting;     // freeze fetch
    addr_t    fetch_addr;
    instr_t   fetch_instr;
    reg_idx_t rd_idx, rs_idx, rt_idx;
    word_t    rd_data, rs_data, rt_data;
    addr_t    data_addr;
    logic     data_we;
    word_t    data_wdata;
    word_t    data_rdata;

    fetch_stage fetch_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .stall       (stall),
        .halting     (halting),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .ifid        (ifid)
    );

    decode_stage decode_stage_inst (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .ifid    (ifid),
        .rd_idx  (rd_idx),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rd_data (rd_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .stall   (stall),
        .halting (halting),
        .idex    (idex)
    );

    register_file register_file_inst (
        .clk     (clk),
        .reset   (reset),
        .wb      (wb),
        .rd_idx  (rd_idx),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rd_data (rd_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_stage execute_stage_inst (
        .clk   (clk),
        .reset (reset),
        .run   (run),
        .idex  (idex),
        .wb    (wb),
        .exmem (exmem)
    );

    memory_stage memory_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .exmem      (exmem),
        .data_addr  (data_addr),
        .data_we    (data_we),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .wb         (wb),
        .hlt        (hlt)
    );

    unified_memory unified_memory_inst (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .data_addr   (data_addr),
        .data_we     (data_we),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .host_req    (host_req),
        .host_write  (host_write),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_ack    (host_ack),
        .host_rdata  (host_rdata)
    );

endmodule

//--- verilog/tinker_pkg.sv
package tinker_pkg;

    typedef logic [63:0] word_t;     // register / memory doubleword
    typedef logic [31:0] addr_t;     // byte address
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] lit_t;      // instr[11:0]
    typedef logic [4:0]  opcode_t;   // instr[31:27]

    // host port handshake
    typedef enum logic [1:0] {
        idle,
        ack_high,
        wait_release
    } host_state_e;

    localparam addr_t  PC_RESET_ADDR = 32'h2000;
    localparam int     MEM_BYTES     = 16384;
    localparam int     MEM_AW        = $clog2(MEM_BYTES);
    localparam instr_t NOP_INSTR     = 32'h8800_0000;   // mov r0,r0

    localparam opcode_t OP_AND    = 5'h00;
    localparam opcode_t OP_OR     = 5'h01;
    localparam opcode_t OP_XOR    = 5'h02;
    localparam opcode_t OP_NOT    = 5'h03;
    localparam opcode_t OP_SHFTR  = 5'h04;
    localparam opcode_t OP_SHFTRI = 5'h05;
    localparam opcode_t OP_SHFTL  = 5'h06;
    localparam opcode_t OP_SHFTLI = 5'h07;
    localparam opcode_t OP_HALT   = 5'h0f;
    localparam opcode_t OP_LOAD   = 5'h10;   // mov rd,(rs)(L)
    localparam opcode_t OP_MOV_RR = 5'h11;
    localparam opcode_t OP_MOV_RL = 5'h12;
    localparam opcode_t OP_STORE  = 5'h13;   // mov (rd)(L),rs
    localparam opcode_t OP_ADD    = 5'h18;
    localparam opcode_t OP_ADDI   = 5'h19;
    localparam opcode_t OP_SUB    = 5'h1a;
    localparam opcode_t OP_SUBI   = 5'h1b;
    localparam opcode_t OP_MUL    = 5'h1c;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;   // wb takes load data
        logic halt;
    } ctrl_t;

    typedef struct packed {
        instr_t instr;
    } ifid_t;

    typedef struct packed {
        ctrl_t    ctrl;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        lit_t     lit;
        word_t    rd_val;
        word_t    rs_val;
        word_t    rt_val;
    } idex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;   // also the load/store address
        word_t    store_data;
        reg_idx_t dest;
    } exmem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    mem_data;
        word_t    alu_result;
        reg_idx_t dest;
    } memwb_t;

    // writeback channel, seen by regfile and forwarding
    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

endpackage

//--- verilog/unified_memory.sv
`timescale 1ns/1ns

module unified_memory
    import tinker_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   run,
    input  addr_t  fetch_addr,
    output instr_t fetch_instr,
    input  addr_t  data_addr,
    input  logic   data_we,
    input  word_t  data_wdata,
    output word_t  data_rdata,
    input  logic   host_req,
    input  logic   host_write,
    input  addr_t  host_addr,
    input  word_t  host_wdata,
    output logic   host_ack,
    output word_t  host_rdata
);

    logic [7:0]  mem [MEM_BYTES];   // byte array, little-endian
    host_state_e state;
    logic        host_grant;        // host access this edge

    // address wraps at MEM_BYTES
    function automatic word_t read_dword(input addr_t a);
        word_t d;
        for (int k = 0; k < 8; k++)
            d[8*k +: 8] = mem[MEM_AW'(a + addr_t'(k))];
        return d;
    endfunction

    always_comb begin
        for (int k = 0; k < 4; k++)
            fetch_instr[8*k +: 8] = mem[MEM_AW'(fetch_addr + addr_t'(k))];
    end

    always_comb begin
        data_rdata = read_dword(data_addr);
    end

    // host only gets memory while the core is parked
    assign host_grant = (state == idle) && host_req && !run;
    assign host_ack   = (state != idle);

    always_ff @(posedge clk) begin
        if (data_we) begin
            for (int k = 0; k < 8; k++)
                mem[MEM_AW'(data_addr + addr_t'(k))] <= data_wdata[8*k +: 8];
        end
        if (host_grant) begin
            if (host_write) begin
                for (int k = 0; k < 8; k++)
                    mem[MEM_AW'(host_addr + addr_t'(k))] <= host_wdata[8*k +: 8];
            end else begin
                host_rdata <= read_dword(host_addr);
            end
        end
    end

    // four-phase req/ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle:         if (host_grant) state <= ack_high;
                ack_high:     if (!host_req) state <= wait_release;   // req seen low
                wait_release: state <= idle;                          // ack drops here
                default:      state <= idle;
            endcase
        end
    end

endmodule
